// File: fpir_pkg.sv
// Shared FPIR field widths, type codes, controller state codes and the FPIR word layout
package fpir_pkg;

	// ****************************************
	// Field widths
	// ****************************************
	localparam int BW_FPIR_TYPE   = 3;
	localparam int BW_EXPONENT    = 10;
	localparam int BW_SIGNIFICAND = 24;
	localparam int BW_GUARD       = 3;
	localparam int BW_OVERFLOW    = 2;

	// Type, sign, exponent, significand, guard and overflow together
	localparam int BW_FPIR_VALUE = BW_FPIR_TYPE + 1 + BW_EXPONENT + BW_SIGNIFICAND
		+ BW_GUARD + BW_OVERFLOW;

	// Full significand product and the step count of the shift-add loop
	localparam int BW_PRODUCT    = 2 * BW_SIGNIFICAND;
	localparam int BW_STEP_COUNT = $clog2(BW_SIGNIFICAND);

	// Exponent sum gets two extra bits so it never wraps before the range check
	localparam int BW_EXP_SUM = BW_EXPONENT + 2;
	localparam int EXP_MAX    = (2 ** (BW_EXPONENT - 1)) - 1;
	localparam int EXP_MIN    = -(2 ** (BW_EXPONENT - 1));

	// ****************************************
	// Type codes
	// ****************************************
	localparam logic [BW_FPIR_TYPE-1:0] FPIR_TYPE_NAN    = 3'd0;
	localparam logic [BW_FPIR_TYPE-1:0] FPIR_TYPE_PINF   = 3'd1;
	localparam logic [BW_FPIR_TYPE-1:0] FPIR_TYPE_MINF   = 3'd2;
	localparam logic [BW_FPIR_TYPE-1:0] FPIR_TYPE_PZERO  = 3'd3;
	localparam logic [BW_FPIR_TYPE-1:0] FPIR_TYPE_MZERO  = 3'd4;
	localparam logic [BW_FPIR_TYPE-1:0] FPIR_TYPE_NORMAL = 3'd5;

	// Overflow flag values, bit 0 out of range and bit 1 set for too small
	localparam logic [BW_OVERFLOW-1:0] OVF_NONE  = 2'b00;
	localparam logic [BW_OVERFLOW-1:0] OVF_LARGE = 2'b01;
	localparam logic [BW_OVERFLOW-1:0] OVF_SMALL = 2'b11;

	// Multiply controller states
	localparam int BW_CTRL_STATE = 2;
	localparam logic [BW_CTRL_STATE-1:0] CTRL_IDLE   = 2'd0;
	localparam logic [BW_CTRL_STATE-1:0] CTRL_LOAD   = 2'd1;
	localparam logic [BW_CTRL_STATE-1:0] CTRL_STEP   = 2'd2;
	localparam logic [BW_CTRL_STATE-1:0] CTRL_FINISH = 2'd3;

	// FPIR word, most significant field first
	typedef struct packed {
		logic [BW_FPIR_TYPE-1:0]   ftype;
		logic                      sign;
		logic [BW_EXPONENT-1:0]    exponent;
		logic [BW_SIGNIFICAND-1:0] significand;
		logic [BW_GUARD-1:0]       guard;
		logic [BW_OVERFLOW-1:0]    overflow;
	} fpir_t;

endpackage

// File: fpir_mul_if.sv
// Strobes and product bus shared by the multiply controller and the significand datapath
`timescale 1ns/1ps

interface fpir_mul_if
	import fpir_pkg::*;
();

	// Sequencing strobes from the controller
	logic load;
	logic step;
	logic finish;

	// Significand product from the shift-add datapath
	logic [BW_PRODUCT-1:0] product;

	modport ctrl
	(
		output load,
		output step,
		output finish
	);

	modport data
	(
		input  load,
		input  step,
		input  finish,
		output product
	);

endinterface

// File: fpir_mul_type.sv
// Resolves the product type of an FPIR multiply from the two operand types and signs
`timescale 1ns/1ps

module fpir_mul_type
	import fpir_pkg::*;
(
	input  fpir_t                   op_a,
	input  fpir_t                   op_b,
	output logic [BW_FPIR_TYPE-1:0] prod_type
);

	// Special types carry their sign in the code, normal words in the sign field
	function automatic logic operand_negative(input fpir_t op);
		logic neg;
		case (op.ftype)
			FPIR_TYPE_MINF,
			FPIR_TYPE_MZERO:
				neg = 1'b1;
			FPIR_TYPE_NORMAL:
				neg = op.sign;
			default:
				neg = 1'b0;
		endcase
		return neg;
	endfunction

	logic a_nan;
	logic b_nan;
	logic a_inf;
	logic b_inf;
	logic a_zero;
	logic b_zero;
	logic a_normal;
	logic b_normal;
	logic prod_negative;

	// ****************************************
	// Operand classification
	// ****************************************
	assign a_nan    = (op_a.ftype == FPIR_TYPE_NAN);
	assign b_nan    = (op_b.ftype == FPIR_TYPE_NAN);
	assign a_inf    = (op_a.ftype == FPIR_TYPE_PINF) || (op_a.ftype == FPIR_TYPE_MINF);
	assign b_inf    = (op_b.ftype == FPIR_TYPE_PINF) || (op_b.ftype == FPIR_TYPE_MINF);
	assign a_zero   = (op_a.ftype == FPIR_TYPE_PZERO) || (op_a.ftype == FPIR_TYPE_MZERO);
	assign b_zero   = (op_b.ftype == FPIR_TYPE_PZERO) || (op_b.ftype == FPIR_TYPE_MZERO);
	assign a_normal = (op_a.ftype == FPIR_TYPE_NORMAL);
	assign b_normal = (op_b.ftype == FPIR_TYPE_NORMAL);

	assign prod_negative = operand_negative(op_a) ^ operand_negative(op_b);

	// ****************************************
	// Product type table
	// ****************************************
	always_comb
	begin
		if (a_nan || b_nan)
		begin
			prod_type = FPIR_TYPE_NAN;
		end
		else if ((a_inf && b_zero) || (a_zero && b_inf))
		begin
			// Infinity times zero has no defined value
			prod_type = FPIR_TYPE_NAN;
		end
		else if (a_inf || b_inf)
		begin
			prod_type = prod_negative ? FPIR_TYPE_MINF : FPIR_TYPE_PINF;
		end
		else if (a_zero || b_zero)
		begin
			prod_type = prod_negative ? FPIR_TYPE_MZERO : FPIR_TYPE_PZERO;
		end
		else if (a_normal && b_normal)
		begin
			prod_type = FPIR_TYPE_NORMAL;
		end
		else
		begin
			// Unused codes 6 and 7 are treated as not-a-number
			prod_type = FPIR_TYPE_NAN;
		end
	end

endmodule

// File: fpir_mul_ctrl.sv
// FSM that sequences operand load, the shift-add steps, normalization and the done pulse
`timescale 1ns/1ps

module fpir_mul_ctrl
	import fpir_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      start,
	input  logic      special,
	output logic      busy,
	output logic      done,
	fpir_mul_if.ctrl  mul,
	input  logic      last,
	output logic      cnt_load,
	output logic      cnt_step
);

	logic [BW_CTRL_STATE-1:0] state;
	logic [BW_CTRL_STATE-1:0] state_next;
	logic                     accept;

	// New work only while idle and not in the done cycle
	assign accept = start && !busy;

	always_comb
	begin
		state_next = state;
		case (state)
			CTRL_IDLE:
				if (accept)
					state_next = CTRL_LOAD;
			CTRL_LOAD:
				// Special products skip the whole significand loop
				state_next = special ? CTRL_FINISH : CTRL_STEP;
			CTRL_STEP:
				if (last)
					state_next = CTRL_FINISH;
			default:
				state_next = CTRL_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= CTRL_IDLE;
			done  <= 1'b0;
		end
		else
		begin
			state <= state_next;
			done  <= (state == CTRL_FINISH);
		end
	end

	// Strobes decode straight from the state
	assign mul.load   = (state == CTRL_LOAD);
	assign mul.step   = (state == CTRL_STEP);
	assign mul.finish = (state == CTRL_FINISH);
	assign cnt_load   = (state == CTRL_LOAD);
	assign cnt_step   = (state == CTRL_STEP);

	// Busy stays up through the done cycle
	assign busy = (state != CTRL_IDLE) || done;

endmodule

// File: fpir_mul_step_counter.sv
// Counts the remaining shift-add steps and flags the final one to the controller
`timescale 1ns/1ps

module fpir_mul_step_counter
	import fpir_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic load,
	input  logic step,
	output logic last
);

	logic [BW_STEP_COUNT-1:0] count;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			count <= '0;
		end
		else if (load)
		begin
			// One step per significand bit, counted down to zero
			count <= BW_STEP_COUNT'(BW_SIGNIFICAND - 1);
		end
		else if (step && (count != '0))
		begin
			count <= count - 1'b1;
		end
	end

	assign last = (count == '0);

endmodule

// File: fpir_sig_multiplier.sv
// Shift-add significand multiplier that retires one multiplier bit per step strobe
`timescale 1ns/1ps

module fpir_sig_multiplier
	import fpir_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [BW_SIGNIFICAND-1:0] sig_a,
	input  logic [BW_SIGNIFICAND-1:0] sig_b,
	fpir_mul_if.data                  mul
);

	logic [BW_SIGNIFICAND-1:0] mcand;
	logic [BW_SIGNIFICAND-1:0] mplier;
	logic [BW_PRODUCT-1:0]     acc;
	logic [BW_SIGNIFICAND:0]   partial_sum;

	// Upper half plus the multiplicand when the current multiplier bit is one
	assign partial_sum = {1'b0, acc[BW_PRODUCT-1:BW_SIGNIFICAND]}
		+ {1'b0, (mplier[0] ? mcand : {BW_SIGNIFICAND{1'b0}})};

	// Multiplicand only changes on load
	always_ff @(posedge clk)
	begin
		if (mul.load)
			mcand <= sig_a;
	end

	// ****************************************
	// Accumulate and shift
	// ****************************************
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			mplier <= '0;
			acc    <= '0;
		end
		else if (mul.load)
		begin
			mplier <= sig_b;
			acc    <= '0;
		end
		else if (mul.step)
		begin
			mplier <= mplier >> 1;
			// Carry of the add moves into the top, low product bits drop in from above
			acc    <= {partial_sum, acc[BW_SIGNIFICAND-1:1]};
		end
	end

	// After the last step the accumulator holds the full product
	assign mul.product = acc;

endmodule

// File: fpir_mul_normalize.sv
// Normalizes the significand product and registers the final FPIR result on finish
`timescale 1ns/1ps

module fpir_mul_normalize
	import fpir_pkg::*;
(
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [BW_FPIR_TYPE-1:0]        prod_type,
	input  logic                           sign,
	input  logic signed [BW_EXPONENT-1:0]  exp_a,
	input  logic signed [BW_EXPONENT-1:0]  exp_b,
	fpir_mul_if.data                       mul,
	output fpir_t                          result
);

	logic                          top_bit;
	logic [BW_SIGNIFICAND-1:0]     sig_n;
	logic [BW_GUARD-2:0]           grd_n;
	logic                          sticky_n;
	logic signed [BW_EXP_SUM-1:0]  exp_a_x;
	logic signed [BW_EXP_SUM-1:0]  exp_b_x;
	logic signed [BW_EXP_SUM-1:0]  exp_sum;
	logic [BW_OVERFLOW-1:0]        ovf_n;

	// Product of two [1,2) significands lies in [1,4), bit 47 marks the upper half
	assign top_bit = mul.product[BW_PRODUCT-1];

	always_comb
	begin
		if (top_bit)
		begin
			sig_n    = mul.product[BW_PRODUCT-1 -: BW_SIGNIFICAND];
			grd_n    = mul.product[BW_SIGNIFICAND-1 -: BW_GUARD-1];
			sticky_n = |mul.product[BW_SIGNIFICAND-BW_GUARD:0];
		end
		else
		begin
			sig_n    = mul.product[BW_PRODUCT-2 -: BW_SIGNIFICAND];
			grd_n    = mul.product[BW_SIGNIFICAND-2 -: BW_GUARD-1];
			sticky_n = |mul.product[BW_SIGNIFICAND-BW_GUARD-1:0];
		end
	end

	// ****************************************
	// Exponent and range check
	// ****************************************
	assign exp_a_x = exp_a;
	assign exp_b_x = exp_b;
	assign exp_sum = exp_a_x + exp_b_x + $signed({{(BW_EXP_SUM-1){1'b0}}, top_bit});

	always_comb
	begin
		if (exp_sum > EXP_MAX)
			ovf_n = OVF_LARGE;
		else if (exp_sum < EXP_MIN)
			ovf_n = OVF_SMALL;
		else
			ovf_n = OVF_NONE;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			result <= '0;
		end
		else if (mul.finish)
		begin
			if (prod_type == FPIR_TYPE_NORMAL)
			begin
				result.ftype       <= prod_type;
				result.sign        <= sign;
				result.exponent    <= exp_sum[BW_EXPONENT-1:0];
				result.significand <= sig_n;
				result.guard       <= {grd_n, sticky_n};
				result.overflow    <= ovf_n;
			end
			else
			begin
				// Special words carry only the type code
				result       <= '0;
				result.ftype <= prod_type;
			end
		end
	end

endmodule

// File: fpir_mul_top.sv
// Top level of the sequential FPIR multiplier, start with operands and collect result on done
`timescale 1ns/1ps

module fpir_mul_top
	import fpir_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic [BW_FPIR_VALUE-1:0] op_a,
	input  logic [BW_FPIR_VALUE-1:0] op_b,
	output logic                     busy,
	output logic                     done,
	output logic [BW_FPIR_VALUE-1:0] result
);

	fpir_t                   op_a_q;
	fpir_t                   op_b_q;
	fpir_t                   result_s;
	logic                    accept;
	logic [BW_FPIR_TYPE-1:0] prod_type;
	logic                    special;
	logic                    prod_sign;
	logic                    last;
	logic                    cnt_load;
	logic                    cnt_step;

	fpir_mul_if mul_if ();

	// Operands are captured only for an accepted start
	assign accept = start && !busy;

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op_a_q <= op_a;
			op_b_q <= op_b;
		end
	end

	assign special   = (prod_type != FPIR_TYPE_NORMAL);
	assign prod_sign = op_a_q.sign ^ op_b_q.sign;
	assign result    = result_s;

	// ****************************************
	// Blocks
	// ****************************************
	fpir_mul_type type_i (.op_a(op_a_q), .op_b(op_b_q), .prod_type(prod_type));

	fpir_mul_ctrl ctrl_i (
		.clk(clk), .rst_n(rst_n), .start(start), .special(special), .busy(busy),
		.done(done), .mul(mul_if.ctrl), .last(last), .cnt_load(cnt_load),
		.cnt_step(cnt_step));

	fpir_mul_step_counter counter_i (
		.clk(clk), .rst_n(rst_n), .load(cnt_load), .step(cnt_step), .last(last));

	fpir_sig_multiplier sig_mul_i (
		.clk(clk), .rst_n(rst_n), .sig_a(op_a_q.significand), .sig_b(op_b_q.significand),
		.mul(mul_if.data));

	fpir_mul_normalize normalize_i (
		.clk(clk), .rst_n(rst_n), .prod_type(prod_type), .sign(prod_sign),
		.exp_a(op_a_q.exponent), .exp_b(op_b_q.exponent), .mul(mul_if.data),
		.result(result_s));

endmodule

// File: tb_fpir_mul.sv
// Testbench for the FPIR multiplier, replays the pattern file through the top level and checks results
`timescale 1ns/1ps

module tb_fpir_mul
	import fpir_pkg::*;
();

	localparam real CLK_PERIOD      = 4.0;
	localparam real DRIVE_DELAY     = 0.5;
	localparam int  RESET_CYCLES    = 4;
	localparam int  CASE_CYCLES     = 30;
	localparam int  SPECIAL_LATENCY = 2;
	localparam int  NORMAL_LATENCY  = 2 + BW_SIGNIFICAND;
	localparam      PATTERN_FILE    = "fpir_mul_patterns.txt";

	logic                     clk;
	logic                     rst_n;
	logic                     start;
	logic [BW_FPIR_VALUE-1:0] op_a;
	logic [BW_FPIR_VALUE-1:0] op_b;
	logic                     busy;
	logic                     done;
	logic [BW_FPIR_VALUE-1:0] result;

	// Pattern columns, one entry per case
	logic [BW_FPIR_VALUE-1:0] pat_a[$];
	logic [BW_FPIR_VALUE-1:0] pat_b[$];
	logic [BW_FPIR_VALUE-1:0] pat_exp[$];
	bit                       patterns_loaded = 1'b0;

	fpir_mul_top dut_i (
		.clk(clk), .rst_n(rst_n), .start(start), .op_a(op_a), .op_b(op_b),
		.busy(busy), .done(done), .result(result));

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	// ****************************************
	// Clock and watchdog
	// ****************************************
	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2.0) clk = ~clk;
	end

	initial
	begin
		wait (patterns_loaded);
		#((pat_a.size() * CASE_CYCLES + RESET_CYCLES) * CLK_PERIOD);
		report_failure("Timeout: the multiplier did not finish all patterns in time");
	end

	task automatic load_patterns();
		int                       fd;
		int                       count;
		string                    line;
		logic [BW_FPIR_VALUE-1:0] a;
		logic [BW_FPIR_VALUE-1:0] b;
		logic [BW_FPIR_VALUE-1:0] expected;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0)
			report_failure("Could not open the pattern file");
		while (!$feof(fd))
		begin
			count = $fgets(line, fd);
			// Lines starting with # are comments
			if (count > 0 && line.len() > 0 && line[0] != "#")
			begin
				if ($sscanf(line, "%h %h %h", a, b, expected) == 3)
				begin
					pat_a.push_back(a);
					pat_b.push_back(b);
					pat_exp.push_back(expected);
				end
			end
		end
		$fclose(fd);
		if (pat_a.size() == 0)
			report_failure("The pattern file holds no cases");
		patterns_loaded = 1'b1;
	endtask

	task automatic check_reset_values();
		assert (busy === 1'b0)
			else report_failure($sformatf("Fail busy after reset: got %h expected 0", busy));
		assert (done === 1'b0)
			else report_failure($sformatf("Fail done after reset: got %h expected 0", done));
		assert (result === '0)
			else report_failure($sformatf("Fail result after reset: got %h expected 0", result));
	endtask

	// ****************************************
	// One multiply from start to done
	// ****************************************
	task automatic run_case(input int idx);
		logic [BW_FPIR_VALUE-1:0] a;
		logic [BW_FPIR_VALUE-1:0] b;
		logic [BW_FPIR_VALUE-1:0] expected;
		int                       exp_cycles;
		int                       cycles;
		bit                       extra_start;
		a        = pat_a[idx];
		b        = pat_b[idx];
		expected = pat_exp[idx];
		// Normal products run the full significand loop
		if (expected[BW_FPIR_VALUE-1 -: BW_FPIR_TYPE] == FPIR_TYPE_NORMAL)
			exp_cycles = NORMAL_LATENCY;
		else
			exp_cycles = SPECIAL_LATENCY;
		// Every odd case gets a second start while busy, with other operands
		extra_start = idx[0];

		@(posedge clk);
		#DRIVE_DELAY;
		start = 1'b1;
		op_a  = a;
		op_b  = b;
		@(posedge clk);
		#DRIVE_DELAY;
		start  = 1'b0;
		cycles = 0;
		do
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
			start = 1'b0;
			if (extra_start && cycles == 1)
			begin
				start = 1'b1;
				op_a  = ~a;
				op_b  = ~b;
			end
			assert (busy === 1'b1)
				else report_failure($sformatf("Fail busy in case %0d: got %h expected 1",
					idx, busy));
		end
		while (done !== 1'b1);

		assert (cycles == exp_cycles)
			else report_failure($sformatf("Fail done delay in case %0d: got %h expected %h",
				idx, cycles, exp_cycles));
		assert (result === expected)
			else report_failure($sformatf("Fail result in case %0d: got %h expected %h",
				idx, result, expected));

		// Done is a single pulse and the result holds afterwards
		@(posedge clk);
		#DRIVE_DELAY;
		assert (done === 1'b0)
			else report_failure($sformatf("Fail done after pulse in case %0d: got %h expected 0",
				idx, done));
		assert (busy === 1'b0)
			else report_failure($sformatf("Fail busy after done in case %0d: got %h expected 0",
				idx, busy));
		assert (result === expected)
			else report_failure($sformatf("Fail result hold in case %0d: got %h expected %h",
				idx, result, expected));
	endtask

	initial
	begin
		rst_n = 1'b0;
		start = 1'b0;
		op_a  = '0;
		op_b  = '0;
		load_patterns();

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		check_reset_values();

		for (int i = 0; i < pat_a.size(); i++)
			run_case(i);

		$display("Checked %0d patterns", pat_a.size());
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: fpir_mul_patterns.txt
# Columns: op_a op_b expected_result, each a 43-bit FPIR word in hex
# Word layout from the top: type(3) sign(1) exponent(10) significand(24) guard(3) overflow(2)
# NaN propagation and infinity times zero
00000000000 00000000000 00000000000
00000000000 50010000000 00000000000
58010000000 00000000000 00000000000
10000000000 00000000000 00000000000
30000000000 00000000000 00000000000
10000000000 30000000000 00000000000
40000000000 20000000000 00000000000
# Signed infinities and zeros, also with a normal operand
10000000000 10000000000 10000000000
10000000000 20000000000 20000000000
20000000000 20000000000 10000000000
10000000000 58010000000 20000000000
50010000000 20000000000 20000000000
20000000000 58010000000 10000000000
30000000000 30000000000 30000000000
30000000000 40000000000 40000000000
40000000000 40000000000 30000000000
58010000000 30000000000 40000000000
40000000000 50010000000 40000000000
58010000000 40000000000 30000000000
# Normal products, with and without the normalization shift
50010000000 50010000000 50010000000
58038000000 50058000000 58092000000
580B0000020 5FFB0000020 50050000044
57FFFFFFFE0 58010000020 5801000000C
50074000000 5FFDC000000 58051800000
56010000000 56010000000 54010000000
# Exponent overflow past both limits
53FF0000000 50030000000 54010000001
5C010000000 5FFF0000000 53FF0000003
51FF8000000 52018000000 54012000001

// File: build.f
fpir_pkg.sv
fpir_mul_if.sv
fpir_mul_type.sv
fpir_mul_ctrl.sv
fpir_mul_step_counter.sv
fpir_sig_multiplier.sv
fpir_mul_normalize.sv
fpir_mul_top.sv
tb_fpir_mul.sv

// File: Bender.yml
package:
  name: fpir_mul

sources:
  - fpir_pkg.sv
  - fpir_mul_if.sv
  - fpir_mul_type.sv
  - fpir_mul_ctrl.sv
  - fpir_mul_step_counter.sv
  - fpir_sig_multiplier.sv
  - fpir_mul_normalize.sv
  - fpir_mul_top.sv
  - target: test
    files:
      - tb_fpir_mul.sv
